//--- hw/nx_ctrl.sv
/* AXI4-Lite register block
   Node configuration, FIFO levels, packet counters and local FIFO read port */
`include "nx_common.svh"
`default_nettype none

module nx_ctrl #(
    parameter int IN_DEPTH  = 4,
    parameter int LOC_DEPTH = 4,
    parameter int EGR_DEPTH = 4
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    // AXI4-Lite write address and data
    input  logic [nx_pkg::NX_AXI_ADDR_W-1:0] s_awaddr_i,
    input  logic                             s_awvalid_i,
    output logic                             s_awready_o,
    input  logic [nx_pkg::NX_WORD_W-1:0]     s_wdata_i,
    input  logic [3:0]                       s_wstrb_i,
    input  logic                             s_wvalid_i,
    output logic                             s_wready_o,
    // AXI4-Lite write response
    output logic [1:0]                       s_bresp_o,
    output logic                             s_bvalid_o,
    input  logic                             s_bready_i,
    // AXI4-Lite read
    input  logic [nx_pkg::NX_AXI_ADDR_W-1:0] s_araddr_i,
    input  logic                             s_arvalid_i,
    output logic                             s_arready_o,
    output logic [nx_pkg::NX_WORD_W-1:0]     s_rdata_o,
    output logic [1:0]                       s_rresp_o,
    output logic                             s_rvalid_o,
    input  logic                             s_rready_i,
    // Local FIFO read side
    input  logic [nx_pkg::NX_WORD_W-1:0]     loc_data_i,
    input  logic                             loc_empty_i,
    output logic                             loc_pop_o,
    // FIFO levels
    input  logic [$clog2(IN_DEPTH):0]        in_level_i,
    input  logic [$clog2(LOC_DEPTH):0]       loc_level_i,
    input  logic [$clog2(EGR_DEPTH):0]       egr_level_i,
    // Router configuration and strobes
    nx_route_if.ctrl                         route
);

    // CTRL register fields
    logic                       route_en;
    logic [nx_pkg::NX_ID_W-1:0] node_id;

    // Packet counters
    logic [nx_pkg::NX_WORD_W-1:0] local_cnt;
    logic [nx_pkg::NX_WORD_W-1:0] fwd_cnt;
    logic [nx_pkg::NX_WORD_W-1:0] bad_cnt;

    // Handshake state
    logic aw_hs;
    logic ar_hs;
    logic bvalid;
    logic rvalid;

    // Read decode
    logic [nx_pkg::NX_WORD_W-1:0] ctrl_word;
    logic [nx_pkg::NX_WORD_W-1:0] status_word;
    logic [nx_pkg::NX_WORD_W-1:0] rd_word;
    logic                         rd_err;
    logic                         wr_ok;

    assign route.route_en = route_en;
    assign route.node_id  = node_id;

    // Address and data accepted together in a single-cycle pulse
    assign s_awready_o = aw_hs;
    assign s_wready_o  = aw_hs;
    assign s_bvalid_o  = bvalid;
    assign s_rvalid_o  = rvalid;
    // New read address only once the previous data is taken
    assign s_arready_o = !rvalid;
    assign ar_hs       = s_arvalid_i && !rvalid;

    assign ctrl_word   = {17'd0, node_id, 7'd0, route_en};
    assign status_word = {8'd0, 8'(egr_level_i), 8'(loc_level_i), 8'(in_level_i)};

    // CTRL is the only writable offset
    assign wr_ok = (s_awaddr_i == nx_pkg::NX_REG_CTRL);

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (s_araddr_i)
            nx_pkg::NX_REG_CTRL:      rd_word = ctrl_word;
            nx_pkg::NX_REG_STATUS:    rd_word = status_word;
            nx_pkg::NX_REG_LOCAL_CNT: rd_word = local_cnt;
            nx_pkg::NX_REG_FWD_CNT:   rd_word = fwd_cnt;
            nx_pkg::NX_REG_BAD_CNT:   rd_word = bad_cnt;
            nx_pkg::NX_REG_RX_DATA: begin
                // Empty local FIFO reads as an error with zero data
                rd_word = loc_empty_i ? '0 : loc_data_i;
                rd_err  = loc_empty_i;
            end
            default:                  rd_err = 1'b1;
        endcase
    end

    // Head leaves the local FIFO in the address-accept cycle
    assign loc_pop_o = ar_hs && (s_araddr_i == nx_pkg::NX_REG_RX_DATA) && !loc_empty_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            aw_hs     <= 1'b0;
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            route_en  <= 1'b0;
            node_id   <= '0;
            local_cnt <= '0;
            fwd_cnt   <= '0;
            bad_cnt   <= '0;
        end else begin
            aw_hs <= s_awvalid_i && s_wvalid_i && !bvalid && !aw_hs;
            // Write lands on the handshake edge
            if (aw_hs) begin
                bvalid <= 1'b1;
                if (wr_ok && s_wstrb_i[0]) begin
                    route_en <= s_wdata_i[0];
                end
                if (wr_ok && s_wstrb_i[1]) begin
                    node_id <= s_wdata_i[8 +: nx_pkg::NX_ID_W];
                end
            end else if (s_bready_i) begin
                bvalid <= 1'b0;
            end
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (s_rready_i) begin
                rvalid <= 1'b0;
            end
            // Counters wrap
            local_cnt <= local_cnt + {31'd0, route.local_pkt};
            fwd_cnt   <= fwd_cnt + {31'd0, route.fwd_pkt};
            bad_cnt   <= bad_cnt + {31'd0, route.bad_word};
        end
    end

    // Response payload
    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            s_bresp_o <= wr_ok ? nx_pkg::NX_RESP_OKAY : nx_pkg::NX_RESP_SLVERR;
        end
        if (ar_hs) begin
            s_rdata_o <= rd_word;
            s_rresp_o <= rd_err ? nx_pkg::NX_RESP_SLVERR : nx_pkg::NX_RESP_OKAY;
        end
    end

    // Responses stay up until the master takes them
    `NX_ASSERT(a_bvalid_hold, clk_i, rst_i, (bvalid && !s_bready_i) |=> bvalid);
    `NX_ASSERT(a_rvalid_hold, clk_i, rst_i, (rvalid && !s_rready_i) |=> rvalid);

endmodule

`default_nettype wire

//--- hw/nx_fifo.sv
/* Parameterised FIFO
   Circular buffer with wrapping pointers, level count and status flags */
`include "nx_common.svh"
`default_nettype none

module nx_fifo #(
    parameter int DEPTH    = 2,
    parameter int WIDTH    = 32,
    parameter int FULL_LVL = DEPTH
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Write side
    input  logic [WIDTH-1:0]       wr_data_i,
    input  logic                   wr_push_i,
    // Read side
    output logic [WIDTH-1:0]       rd_data_o,
    input  logic                   rd_pop_i,
    // Status
    output logic [$clog2(DEPTH):0] level_o,
    output logic                   empty_o,
    output logic                   full_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int LVL_W = PTR_W + 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    // Storage and pointers
    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [LVL_W-1:0] level;
    logic             truly_full;
    logic             do_push;
    logic             do_pop;

    // Head word is visible without a read cycle
    assign rd_data_o = mem[rd_ptr];
    assign level_o   = level;
    assign empty_o   = (level == '0);
    assign full_o    = (level >= LVL_W'(FULL_LVL));

    assign truly_full = (level == LVL_W'(DEPTH));

    // Pop only real data
    assign do_pop  = rd_pop_i && !empty_o;
    // A push into a full buffer needs the head leaving in the same cycle
    assign do_push = wr_push_i && (!truly_full || do_pop);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            // Level moves only when exactly one side is active
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Entry write
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // Producer respects full and consumer respects empty
    `NX_ASSERT(a_no_overflow, clk_i, rst_i, (wr_push_i && truly_full) |-> rd_pop_i);
    `NX_ASSERT(a_no_underflow, clk_i, rst_i, rd_pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- hw/nx_msg_router.sv
/* Message router
   Frames packets from the inbound FIFO and steers them to local or egress */
`include "nx_common.svh"
`default_nettype none

module nx_msg_router (
    input  logic                          clk_i,
    input  logic                          rst_i,
    // Inbound FIFO head
    input  nx_pkg::nx_word_t              in_data_i,
    input  logic                          in_empty_i,
    output logic                          in_pop_o,
    // Local FIFO write side
    output logic [nx_pkg::NX_WORD_W-1:0]  loc_data_o,
    output logic                          loc_push_o,
    input  logic                          loc_full_i,
    // Egress FIFO write side
    output logic [nx_pkg::NX_WORD_W-1:0]  egr_data_o,
    output logic                          egr_push_o,
    input  logic                          egr_full_i,
    // Configuration and event strobes
    nx_route_if.router                    route
);

    // Packet state
    logic       pkt_open;
    logic       pkt_local;
    logic [7:0] pkt_left;

    // Decode of the current head word
    logic is_hdr;
    logic hdr_local;
    logic to_local;
    logic dst_full;
    logic drop;
    logic fire;

    always_comb begin
        is_hdr    = in_data_i.pld.is_hdr;
        hdr_local = (in_data_i.hdr.tgt_id == route.node_id);
        // Header picks its own destination and payload follows the open packet
        to_local  = is_hdr ? hdr_local : pkt_local;
        dst_full  = to_local ? loc_full_i : egr_full_i;
        // Stray payload with no packet open
        drop      = !is_hdr && !pkt_open;
        // Word leaves the inbound FIFO this cycle
        fire      = route.route_en && !in_empty_i && (drop || !dst_full);
    end

    assign in_pop_o   = fire;
    assign loc_push_o = fire && !drop && to_local;
    assign egr_push_o = fire && !drop && !to_local;

    // Same word to both sides and the push selects the taker
    assign loc_data_o = in_data_i;
    assign egr_data_o = in_data_i;

    // Counter strobes
    assign route.local_pkt = fire && is_hdr && hdr_local;
    assign route.fwd_pkt   = fire && is_hdr && !hdr_local;
    assign route.bad_word  = fire && drop;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pkt_open  <= 1'b0;
            pkt_local <= 1'b0;
            pkt_left  <= 8'd0;
        end else if (fire && is_hdr) begin
            // New header ends any open packet
            pkt_open  <= (in_data_i.hdr.length != 8'd0);
            pkt_local <= hdr_local;
            pkt_left  <= in_data_i.hdr.length;
        end else if (fire && !drop) begin
            pkt_left <= pkt_left - 8'd1;
            // Last payload word closes the packet
            if (pkt_left == 8'd1) begin
                pkt_open <= 1'b0;
            end
        end
    end

    `NX_ASSERT(a_one_dest, clk_i, rst_i, !(loc_push_o && egr_push_o));

endmodule

`default_nettype wire

//--- hw/nx_msg_top.sv
/* Message node top level
   Inbound, local and egress FIFOs around the router and register block */
`default_nettype none

module nx_msg_top #(
    parameter int IN_DEPTH  = 4,
    parameter int LOC_DEPTH = 4,
    parameter int EGR_DEPTH = 4
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    // Ingress stream
    input  logic [nx_pkg::NX_WORD_W-1:0]     in_data_i,
    input  logic                             in_valid_i,
    output logic                             in_ready_o,
    // Egress stream
    output logic [nx_pkg::NX_WORD_W-1:0]     egr_data_o,
    output logic                             egr_valid_o,
    input  logic                             egr_ready_i,
    // AXI4-Lite slave
    input  logic [nx_pkg::NX_AXI_ADDR_W-1:0] s_awaddr_i,
    input  logic                             s_awvalid_i,
    output logic                             s_awready_o,
    input  logic [nx_pkg::NX_WORD_W-1:0]     s_wdata_i,
    input  logic [3:0]                       s_wstrb_i,
    input  logic                             s_wvalid_i,
    output logic                             s_wready_o,
    output logic [1:0]                       s_bresp_o,
    output logic                             s_bvalid_o,
    input  logic                             s_bready_i,
    input  logic [nx_pkg::NX_AXI_ADDR_W-1:0] s_araddr_i,
    input  logic                             s_arvalid_i,
    output logic                             s_arready_o,
    output logic [nx_pkg::NX_WORD_W-1:0]     s_rdata_o,
    output logic [1:0]                       s_rresp_o,
    output logic                             s_rvalid_o,
    input  logic                             s_rready_i
);

    // Inbound FIFO
    logic [nx_pkg::NX_WORD_W-1:0] in_head;
    logic [$clog2(IN_DEPTH):0]    in_level;
    logic                         in_empty;
    logic                         in_full;
    logic                         in_pop;

    // Local FIFO
    logic [nx_pkg::NX_WORD_W-1:0] loc_wdata;
    logic [nx_pkg::NX_WORD_W-1:0] loc_head;
    logic [$clog2(LOC_DEPTH):0]   loc_level;
    logic                         loc_push;
    logic                         loc_pop;
    logic                         loc_empty;
    logic                         loc_full;

    // Egress FIFO
    logic [nx_pkg::NX_WORD_W-1:0] egr_wdata;
    logic [$clog2(EGR_DEPTH):0]   egr_level;
    logic                         egr_push;
    logic                         egr_empty;
    logic                         egr_full;

    nx_route_if u_route_if ();

    // Stream handshakes
    assign in_ready_o  = !in_full;
    assign egr_valid_o = !egr_empty;

    nx_fifo #(.DEPTH(IN_DEPTH), .WIDTH(nx_pkg::NX_WORD_W)) u_in_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_data_i (in_data_i),
        .wr_push_i (in_valid_i && !in_full),
        .rd_data_o (in_head),
        .rd_pop_i  (in_pop),
        .level_o   (in_level),
        .empty_o   (in_empty),
        .full_o    (in_full)
    );

    nx_fifo #(.DEPTH(LOC_DEPTH), .WIDTH(nx_pkg::NX_WORD_W)) u_loc_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_data_i (loc_wdata),
        .wr_push_i (loc_push),
        .rd_data_o (loc_head),
        .rd_pop_i  (loc_pop),
        .level_o   (loc_level),
        .empty_o   (loc_empty),
        .full_o    (loc_full)
    );

    nx_fifo #(.DEPTH(EGR_DEPTH), .WIDTH(nx_pkg::NX_WORD_W)) u_egr_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_data_i (egr_wdata),
        .wr_push_i (egr_push),
        .rd_data_o (egr_data_o),
        .rd_pop_i  (egr_ready_i && !egr_empty),
        .level_o   (egr_level),
        .empty_o   (egr_empty),
        .full_o    (egr_full)
    );

    nx_msg_router u_router (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .in_data_i  (in_head),
        .in_empty_i (in_empty),
        .in_pop_o   (in_pop),
        .loc_data_o (loc_wdata),
        .loc_push_o (loc_push),
        .loc_full_i (loc_full),
        .egr_data_o (egr_wdata),
        .egr_push_o (egr_push),
        .egr_full_i (egr_full),
        .route      (u_route_if.router)
    );

    nx_ctrl #(
        .IN_DEPTH  (IN_DEPTH),
        .LOC_DEPTH (LOC_DEPTH),
        .EGR_DEPTH (EGR_DEPTH)
    ) u_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .loc_data_i  (loc_head),
        .loc_empty_i (loc_empty),
        .loc_pop_o   (loc_pop),
        .in_level_i  (in_level),
        .loc_level_i (loc_level),
        .egr_level_i (egr_level),
        .route       (u_route_if.ctrl)
    );

endmodule

`default_nettype wire

//--- hw/nx_pkg.sv
/* Message node package
   Word and ID widths, the message word layout and the register map */
`default_nettype none

package nx_pkg;

    // Datapath and node ID widths
    localparam int NX_WORD_W = 32;
    localparam int NX_ID_W   = 7;

    // One 32-bit word, read either as a header or as a payload
    typedef union packed {
        struct packed {
            logic               is_hdr;
            logic [NX_ID_W-1:0] tgt_id;
            logic [15:0]        cmd;
            // Payload words following this header
            logic [7:0]         length;
        } hdr;
        struct packed {
            logic               is_hdr;
            logic [30:0]        data;
        } pld;
    } nx_word_t;

    // AXI4-Lite address width
    localparam int NX_AXI_ADDR_W = 8;

    // Register offsets
    localparam logic [NX_AXI_ADDR_W-1:0] NX_REG_CTRL      = 8'h00;
    localparam logic [NX_AXI_ADDR_W-1:0] NX_REG_STATUS    = 8'h04;
    localparam logic [NX_AXI_ADDR_W-1:0] NX_REG_RX_DATA   = 8'h08;
    localparam logic [NX_AXI_ADDR_W-1:0] NX_REG_LOCAL_CNT = 8'h0C;
    localparam logic [NX_AXI_ADDR_W-1:0] NX_REG_FWD_CNT   = 8'h10;
    localparam logic [NX_AXI_ADDR_W-1:0] NX_REG_BAD_CNT   = 8'h14;

    // AXI response codes
    localparam logic [1:0] NX_RESP_OKAY   = 2'b00;
    localparam logic [1:0] NX_RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- hw/nx_route_if.sv
/* Router configuration and counter strobes
   Control drives the settings, the router drives the per-event strobes */
`default_nettype none

interface nx_route_if;

    // Configuration from the register block
    logic [nx_pkg::NX_ID_W-1:0] node_id;
    logic                       route_en;

    // One-cycle event strobes from the router
    logic local_pkt;
    logic fwd_pkt;
    logic bad_word;

    modport ctrl (
        output node_id, route_en,
        input  local_pkt, fwd_pkt, bad_word
    );

    modport router (
        input  node_id, route_en,
        output local_pkt, fwd_pkt, bad_word
    );

endinterface

`default_nettype wire

//--- include/nx_common.svh
/* Common macros for the message node
   Concurrent assertion wrapper, held off while reset is active */
`ifndef NX_COMMON_SVH
`define NX_COMMON_SVH

// Named concurrent assertion on the rising clock edge
// The check is disabled for as long as the reset input is high
`define NX_ASSERT(name, clk, rst, prop) \
    name : assert property (@(posedge clk) disable iff (rst) (prop))

`endif

//--- nx_msg.f
+incdir+include
hw/nx_pkg.sv
hw/nx_route_if.sv
hw/nx_fifo.sv
hw/nx_msg_router.sv
hw/nx_ctrl.sv
hw/nx_msg_top.sv
tb/nx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the nx_msg testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module nx_tb -f nx_msg.f

# Keep the simulator output even when the run stops on a fatal error
sim_out="$(./obj_dir/Vnx_tb || true)"
printf '%s\n' "$sim_out"

if grep -qx "Test OK" <<< "$sim_out"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- tb/nx_tb.sv
/* Message node testbench
   Drives ingress, egress and AXI4-Lite, checks routing against a packet model */
`default_nettype none

module nx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TIMEOUT_CYCLES = 4000;
    localparam logic [6:0]  MY_ID          = 7'd5;
    // CTRL value with routing on for this node
    localparam logic [31:0] CTRL_ON        = {17'd0, MY_ID, 7'd0, 1'b1};

    // DUT ports
    logic        clk_i;
    logic        rst_i;
    logic [31:0] in_data_i;
    logic        in_valid_i;
    logic        in_ready_o;
    logic [31:0] egr_data_o;
    logic        egr_valid_o;
    logic        egr_ready_i = 1'b0;
    logic [7:0]  s_awaddr_i;
    logic        s_awvalid_i;
    logic        s_awready_o;
    logic [31:0] s_wdata_i;
    logic [3:0]  s_wstrb_i;
    logic        s_wvalid_i;
    logic        s_wready_o;
    logic [1:0]  s_bresp_o;
    logic        s_bvalid_o;
    logic        s_bready_i;
    logic [7:0]  s_araddr_i;
    logic        s_arvalid_i;
    logic        s_arready_o;
    logic [31:0] s_rdata_o;
    logic [1:0]  s_rresp_o;
    logic        s_rvalid_o;
    logic        s_rready_i;

    // Random streams, egress ready control and the run watchdog
    logic [31:0] pld_state  = 32'h1794_5c2a;
    logic [31:0] rdy_state  = 32'h1794_5c2a;
    logic        egr_lcg_en = 1'b0;
    int          release_at = 0;
    int          cycle_cnt  = 0;

    // Packet model with expected words per destination
    logic [31:0] loc_exp[$];
    logic [31:0] egr_exp[$];
    logic [31:0] egr_want;
    int          loc_cnt_exp = 0;
    int          fwd_cnt_exp = 0;
    int          bad_cnt_exp = 0;
    logic        pkt_open_m  = 1'b0;
    logic        pkt_local_m = 1'b0;
    int          pkt_left_m  = 0;

    nx_msg_top #(.IN_DEPTH(4), .LOC_DEPTH(4), .EGR_DEPTH(4)) uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic stop_error(input string msg);
        $display("Test FAILED");
        $display("error at %0d ns: %s", $time, msg);
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] make_payload();
        pld_state = lcg_next(pld_state);
        return {1'b0, pld_state[30:0]};
    endfunction

    function automatic logic [31:0] make_hdr(input logic [6:0] tgt, input logic [7:0] len);
        nx_pkg::nx_word_t w;
        w.hdr.is_hdr = 1'b1;
        w.hdr.tgt_id = tgt;
        w.hdr.cmd    = 16'h5a00 | {8'd0, len};
        w.hdr.length = len;
        return w;
    endfunction

    // Framing rules applied to each accepted word
    task automatic model_word(input logic [31:0] word);
        nx_pkg::nx_word_t w;
        w = word;
        if (w.hdr.is_hdr) begin
            pkt_local_m = (w.hdr.tgt_id == MY_ID);
            pkt_left_m  = int'(w.hdr.length);
            pkt_open_m  = (pkt_left_m != 0);
            if (pkt_local_m) begin
                loc_cnt_exp++;
                loc_exp.push_back(word);
            end else begin
                fwd_cnt_exp++;
                egr_exp.push_back(word);
            end
        end else if (pkt_open_m) begin
            if (pkt_local_m) begin
                loc_exp.push_back(word);
            end else begin
                egr_exp.push_back(word);
            end
            pkt_left_m--;
            pkt_open_m = (pkt_left_m != 0);
        end else begin
            // Stray payload is dropped
            bad_cnt_exp++;
        end
    endtask

    task automatic send_word(input logic [31:0] word);
        @(negedge clk_i);
        in_data_i  = word;
        in_valid_i = 1'b1;
        while (!in_ready_o) @(negedge clk_i);
        // Transfer edge
        @(posedge clk_i);
        model_word(word);
        @(negedge clk_i);
        in_valid_i = 1'b0;
    endtask

    task automatic send_packet(input logic [6:0] tgt, input logic [7:0] len);
        send_word(make_hdr(tgt, len));
        for (int i = 0; i < int'(len); i++) begin
            send_word(make_payload());
        end
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge clk_i);
        s_awaddr_i  = addr;
        s_wdata_i   = data;
        s_wstrb_i   = 4'hf;
        s_awvalid_i = 1'b1;
        s_wvalid_i  = 1'b1;
        // Accepted on the edge after awready shows up
        while (!s_awready_o) @(negedge clk_i);
        @(negedge clk_i);
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
        while (!s_bvalid_o) @(negedge clk_i);
        resp       = s_bresp_o;
        s_bready_i = 1'b1;
        @(negedge clk_i);
        s_bready_i = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge clk_i);
        s_araddr_i  = addr;
        s_arvalid_i = 1'b1;
        while (!s_arready_o) @(negedge clk_i);
        @(negedge clk_i);
        s_arvalid_i = 1'b0;
        while (!s_rvalid_o) @(negedge clk_i);
        data       = s_rdata_o;
        resp       = s_rresp_o;
        s_rready_i = 1'b1;
        @(negedge clk_i);
        s_rready_i = 1'b0;
    endtask

    task automatic check_read(input logic [7:0] addr, input logic [31:0] exp_data,
                              input logic [1:0] exp_resp, input string what);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        assert (data == exp_data && resp == exp_resp)
            else stop_error($sformatf("%s read %h resp %0d, expected %h resp %0d",
                                      what, data, resp, exp_data, exp_resp));
    endtask

    // Poll STATUS until the local FIFO holds lvl words
    task automatic wait_local_level(input logic [7:0] lvl);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(nx_pkg::NX_REG_STATUS, data, resp);
        while (data[15:8] != lvl) begin
            axi_read(nx_pkg::NX_REG_STATUS, data, resp);
        end
    endtask

    task automatic wait_egress_drain();
        while (egr_exp.size() != 0) @(negedge clk_i);
    endtask

    // Changed on the rising edge and picked up by the ready driver
    task automatic set_egress(input logic lcg_en, input int delay);
        @(posedge clk_i);
        release_at = cycle_cnt + delay;
        egr_lcg_en = lcg_en;
    endtask

    // Egress ready pattern
    always @(negedge clk_i) begin
        rdy_state   = lcg_next(rdy_state);
        egr_ready_i = egr_lcg_en && (cycle_cnt >= release_at) && rdy_state[20];
    end

    // Egress words checked against the model in order
    always @(posedge clk_i) begin
        if (!rst_i && egr_valid_o && egr_ready_i) begin
            if (egr_exp.size() == 0) begin
                stop_error($sformatf("egress word %h with none expected", egr_data_o));
            end else begin
                egr_want = egr_exp.pop_front();
                assert (egr_data_o == egr_want)
                    else stop_error($sformatf("egress %h, expected %h", egr_data_o, egr_want));
            end
        end
    end

    a_egr_hold : assert property (@(posedge clk_i) disable iff (rst_i)
        (egr_valid_o && !egr_ready_i) |=> (egr_valid_o && $stable(egr_data_o)))
        else stop_error("egress word changed while stalled");

    a_ar_pending : assert property (@(posedge clk_i) disable iff (rst_i)
        s_rvalid_o |-> !s_arready_o)
        else stop_error("arready high with a read response pending");

    a_aw_w_pair : assert property (@(posedge clk_i) disable iff (rst_i)
        s_awready_o == s_wready_o)
        else stop_error("awready and wready did not rise together");

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Test FAILED");
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $fatal(1);
        end
    end

    initial begin
        logic [1:0] resp;
        rst_i       = 1'b1;
        in_data_i   = '0;
        in_valid_i  = 1'b0;
        s_awaddr_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wstrb_i   = '0;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b0;
        s_araddr_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // Reset state
        assert (in_ready_o && !egr_valid_o && !s_awready_o && !s_wready_o
                && !s_bvalid_o && !s_rvalid_o)
            else stop_error("handshake outputs wrong after reset");
        check_read(nx_pkg::NX_REG_CTRL, 32'd0, nx_pkg::NX_RESP_OKAY, "CTRL");
        check_read(nx_pkg::NX_REG_STATUS, 32'd0, nx_pkg::NX_RESP_OKAY, "STATUS");
        check_read(nx_pkg::NX_REG_LOCAL_CNT, 32'd0, nx_pkg::NX_RESP_OKAY, "LOCAL_CNT");
        check_read(nx_pkg::NX_REG_FWD_CNT, 32'd0, nx_pkg::NX_RESP_OKAY, "FWD_CNT");
        check_read(nx_pkg::NX_REG_BAD_CNT, 32'd0, nx_pkg::NX_RESP_OKAY, "BAD_CNT");
        // Words wait in the inbound FIFO while routing is off
        send_packet(7'd9, 8'd1);
        check_read(nx_pkg::NX_REG_STATUS, 32'd2, nx_pkg::NX_RESP_OKAY, "STATUS routing off");
        assert (!egr_valid_o) else stop_error("egress active with routing off");

        // Local delivery
        set_egress(1'b1, 0);
        axi_write(nx_pkg::NX_REG_CTRL, CTRL_ON, resp);
        assert (resp == nx_pkg::NX_RESP_OKAY) else stop_error("CTRL write not OKAY");
        check_read(nx_pkg::NX_REG_CTRL, CTRL_ON, nx_pkg::NX_RESP_OKAY, "CTRL");
        send_packet(MY_ID, 8'd3);
        wait_local_level(8'd4);
        repeat (4) begin
            check_read(nx_pkg::NX_REG_RX_DATA, loc_exp.pop_front(), nx_pkg::NX_RESP_OKAY,
                       "RX_DATA");
        end
        check_read(nx_pkg::NX_REG_LOCAL_CNT, 32'(loc_cnt_exp), nx_pkg::NX_RESP_OKAY,
                   "LOCAL_CNT");
        check_read(nx_pkg::NX_REG_RX_DATA, 32'd0, nx_pkg::NX_RESP_SLVERR, "RX_DATA empty");

        // Forwarding under a random egress ready
        send_packet(7'd9, 8'd2);
        send_packet(7'd17, 8'd0);
        send_packet(7'd64, 8'd3);
        send_packet(7'd4, 8'd1);
        wait_egress_drain();
        check_read(nx_pkg::NX_REG_FWD_CNT, 32'(fwd_cnt_exp), nx_pkg::NX_RESP_OKAY, "FWD_CNT");

        // Back-pressure fills both inbound and egress
        set_egress(1'b0, 0);
        send_packet(7'd12, 8'd7);
        repeat (2) @(negedge clk_i);
        assert (!in_ready_o) else stop_error("ingress still ready with egress blocked");
        // Extra packet stalls until egress is released
        set_egress(1'b1, 12);
        send_packet(7'd3, 8'd1);
        wait_egress_drain();

        // Stray payloads followed by a local marker
        repeat (3) send_word(make_payload());
        send_packet(MY_ID, 8'd0);
        wait_local_level(8'd1);
        check_read(nx_pkg::NX_REG_RX_DATA, loc_exp.pop_front(), nx_pkg::NX_RESP_OKAY,
                   "RX_DATA marker");
        check_read(nx_pkg::NX_REG_RX_DATA, 32'd0, nx_pkg::NX_RESP_SLVERR, "RX_DATA empty");
        wait_egress_drain();
        check_read(nx_pkg::NX_REG_BAD_CNT, 32'(bad_cnt_exp), nx_pkg::NX_RESP_OKAY, "BAD_CNT");
        check_read(nx_pkg::NX_REG_LOCAL_CNT, 32'(loc_cnt_exp), nx_pkg::NX_RESP_OKAY,
                   "LOCAL_CNT");

        // Write to a read-only register
        axi_write(nx_pkg::NX_REG_STATUS, 32'hffff_ffff, resp);
        assert (resp == nx_pkg::NX_RESP_SLVERR) else stop_error("STATUS write not SLVERR");
        check_read(nx_pkg::NX_REG_CTRL, CTRL_ON, nx_pkg::NX_RESP_OKAY, "CTRL after bad write");
        check_read(nx_pkg::NX_REG_STATUS, 32'd0, nx_pkg::NX_RESP_OKAY, "STATUS at end");
        assert (!egr_valid_o) else stop_error("egress valid after drain");

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
